// File: design/alu.sv
module alu (
  input  core_ctrl_pkg::alu_op_e      op,
  input  logic [rv_isa_pkg::XLEN-1:0] a,
  input  logic [rv_isa_pkg::XLEN-1:0] b,
  output logic [rv_isa_pkg::XLEN-1:0] result,
  output logic                        cond
);

  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  logic [4:0]      shamt;
  logic [XLEN-1:0] sum;
  logic            eq;
  logic            lt_s;
  logic            lt_u;

  assign shamt = b[4:0];
  assign sum   = a + b;
  assign eq    = a == b;
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    // compare ops leave the sum on result
    result = sum;
    cond   = 1'b0;
    case (op)
      ALU_ADD:  result = sum;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      ALU_EQ:   cond = eq;
      ALU_NE:   cond = !eq;
      ALU_LT:   cond = lt_s;
      ALU_GE:   cond = !lt_s;
      ALU_LTU:  cond = lt_u;
      default:  cond = !lt_u;
    endcase
  end

endmodule

// File: design/core_ctrl_pkg.sv
package core_ctrl_pkg;

  import rv_isa_pkg::*;

  // data memory size in 32-bit words
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW = $clog2(DMEM_WORDS);

  // the six compare ops drive cond and leave the sum on result
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic {OP2_REG, OP2_IMM} op2_sel_e;

  typedef enum logic [1:0] {OP1_REG, OP1_PC, OP1_ZERO} op1_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

  // jal jumps to pc + imm and jalr to rs1 + imm with bit 0 cleared
  typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH} npc_sel_e;

  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

  // everything the decoder hands to the execute path
  typedef struct packed {
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
    alu_op_e           alu_op;
    op1_sel_e          op1_sel;
    op2_sel_e          op2_sel;
    wb_sel_e           wb_sel;
    npc_sel_e          npc_sel;
    logic              reg_wen;
    logic              mem_ren;
    logic              mem_wen;
    mem_size_e         mem_size;
    logic              mem_unsigned;
  } ctrl_t;

  // retire report for each accepted instruction
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   next_pc;
    logic              reg_wen;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   wdata;
  } commit_t;

endpackage

// File: design/core_top.sv
module core_top (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic [rv_isa_pkg::XLEN-1:0] inst,
  input  logic                        ivalid,
  output logic [rv_isa_pkg::XLEN-1:0] pc,
  output core_ctrl_pkg::commit_t      commit
);

  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  ctrl_t           ctrl;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wdata;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] next_pc;
  logic            cond;
  logic            misaligned;
  logic            reg_wen;

  idu u_idu (
    .inst   (inst),
    .ivalid (ivalid),
    .ctrl   (ctrl)
  );

  regfile u_regfile (
    .clock  (clock),
    .rst_n  (rst_n),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (reg_wen),
    .waddr  (ctrl.rd),
    .wdata  (wdata)
  );

  assign op_a = (ctrl.op1_sel == OP1_PC) ? pc : ((ctrl.op1_sel == OP1_ZERO) ? '0 : rdata1);
  assign op_b = (ctrl.op2_sel == OP2_IMM) ? ctrl.imm : rdata2;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result),
    .cond   (cond)
  );

  // the alu supplies rs1 + imm as address and rs2 is the store data
  lsu u_lsu (
    .clock       (clock),
    .rst_n       (rst_n),
    .ren         (ctrl.mem_ren),
    .wen         (ctrl.mem_wen),
    .size        (ctrl.mem_size),
    .unsigned_ld (ctrl.mem_unsigned),
    .addr        (alu_result),
    .wdata       (rdata2),
    .rdata       (load_data),
    .misaligned  (misaligned)
  );

  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc + ctrl.imm;

  always_comb begin
    case (ctrl.npc_sel)
      NPC_JAL:    next_pc = br_target;
      NPC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
      NPC_BRANCH: next_pc = cond ? br_target : pc_plus4;
      default:    next_pc = pc_plus4;
    endcase
  end

  assign wdata = (ctrl.wb_sel == WB_LOAD) ? load_data :
                 ((ctrl.wb_sel == WB_PC4) ? pc_plus4 : alu_result);

  // a misaligned load retires without touching rd
  assign reg_wen = ctrl.reg_wen && !misaligned;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (ivalid) begin
      pc <= next_pc;
    end
  end

  assign commit = '{valid: ivalid, pc: pc, next_pc: next_pc, reg_wen: reg_wen,
                    rd: ctrl.rd, wdata: wdata};

endmodule

// File: design/idu.sv
module idu (
  input  logic [rv_isa_pkg::XLEN-1:0] inst,
  input  logic                        ivalid,
  output core_ctrl_pkg::ctrl_t        ctrl
);

  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_lui;
  logic            is_auipc;
  logic            is_jal;
  logic            is_jalr;
  logic            is_branch;
  logic            is_load;
  logic            is_store;
  logic            is_op_imm;
  logic            is_op;
  logic            shift_ok;
  logic [XLEN-1:0] imm;
  alu_op_e         alu_op;
  mem_size_e       mem_size;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // instruction flags, each one only set for a legal encoding
  assign is_lui    = opcode == OPC_LUI;
  assign is_auipc  = opcode == OPC_AUIPC;
  assign is_jal    = opcode == OPC_JAL;
  assign is_jalr   = (opcode == OPC_JALR) && (funct3 == F3_JALR);
  assign is_branch = (opcode == OPC_BRANCH) &&
                     (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
  assign is_load   = (opcode == OPC_LOAD) &&
                     (funct3 inside {F3_MEM_B, F3_MEM_H, F3_MEM_W, F3_MEM_BU, F3_MEM_HU});
  assign is_store  = (opcode == OPC_STORE) && (funct3 inside {F3_MEM_B, F3_MEM_H, F3_MEM_W});

  // shift immediates carry funct7 in imm[11:5]
  assign shift_ok  = (funct3 == F3_SLL) ? (funct7 == FUNCT7_BASE) :
                     (funct3 == F3_SR)  ? (funct7 inside {FUNCT7_BASE, FUNCT7_ALT}) : 1'b1;
  assign is_op_imm = (opcode == OPC_OP_IMM) && shift_ok;
  assign is_op     = (opcode == OPC_OP) &&
                     ((funct7 == FUNCT7_BASE) ||
                      ((funct7 == FUNCT7_ALT) && (funct3 inside {F3_ADD, F3_SR})));

  // immediate by format in the order U, J, B, I and S
  always_comb begin
    imm = '0;
    if (is_lui || is_auipc) begin
      imm = {inst[31:12], 12'b0};
    end else if (is_jal) begin
      imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end else if (is_branch) begin
      imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end else if (is_jalr || is_load || is_op_imm) begin
      imm = {{20{inst[31]}}, inst[31:20]};
    end else if (is_store) begin
      imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    end
  end

  always_comb begin
    alu_op = ALU_ADD;
    if (is_branch) begin
      case (funct3)
        F3_BEQ:  alu_op = ALU_EQ;
        F3_BNE:  alu_op = ALU_NE;
        F3_BLT:  alu_op = ALU_LT;
        F3_BGE:  alu_op = ALU_GE;
        F3_BLTU: alu_op = ALU_LTU;
        default: alu_op = ALU_GEU;
      endcase
    end else if (is_op || is_op_imm) begin
      case (funct3)
        F3_ADD:  alu_op = (is_op && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
        F3_SLL:  alu_op = ALU_SLL;
        F3_SLT:  alu_op = ALU_SLT;
        F3_SLTU: alu_op = ALU_SLTU;
        F3_XOR:  alu_op = ALU_XOR;
        F3_SR:   alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  always_comb begin
    case (funct3)
      F3_MEM_B, F3_MEM_BU: mem_size = MEM_BYTE;
      F3_MEM_H, F3_MEM_HU: mem_size = MEM_HALF;
      default:             mem_size = MEM_WORD;
    endcase
  end

  always_comb begin
    ctrl.rs1          = inst[19:15];
    ctrl.rs2          = inst[24:20];
    ctrl.rd           = inst[11:7];
    ctrl.imm          = imm;
    ctrl.alu_op       = alu_op;
    // lui adds the immediate to zero
    ctrl.op1_sel      = is_lui ? OP1_ZERO : (is_auipc ? OP1_PC : OP1_REG);
    ctrl.op2_sel      = (is_op || is_branch) ? OP2_REG : OP2_IMM;
    ctrl.wb_sel       = is_load ? WB_LOAD : ((is_jal || is_jalr) ? WB_PC4 : WB_ALU);
    ctrl.npc_sel      = is_jal ? NPC_JAL : (is_jalr ? NPC_JALR :
                        (is_branch ? NPC_BRANCH : NPC_SEQ));
    ctrl.reg_wen      = ivalid && (is_lui || is_auipc || is_jal || is_jalr ||
                                   is_load || is_op_imm || is_op);
    ctrl.mem_ren      = ivalid && is_load;
    ctrl.mem_wen      = ivalid && is_store;
    ctrl.mem_size     = mem_size;
    ctrl.mem_unsigned = funct3[2];
  end

  // the lsu and the pc logic both rely on at most one of these
  always_comb begin
    assert ($onehot0({is_load, is_store, is_jal || is_jalr}))
      else $error("idu: load, store and jump decoded together");
  end

endmodule

// File: design/lsu.sv
module lsu (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic                        ren,
  input  logic                        wen,
  input  core_ctrl_pkg::mem_size_e    size,
  input  logic                        unsigned_ld,
  input  logic [rv_isa_pkg::XLEN-1:0] addr,
  input  logic [rv_isa_pkg::XLEN-1:0] wdata,
  output logic [rv_isa_pkg::XLEN-1:0] rdata,
  output logic                        misaligned
);

  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  logic [XLEN-1:0]    mem [DMEM_WORDS];
  logic [1:0]         ofs;
  logic [DMEM_AW-1:0] idx;
  logic [XLEN-1:0]    word;
  logic [XLEN-1:0]    lane;
  logic [XLEN-1:0]    wdata_rep;
  logic [3:0]         be;
  logic               mis_raw;

  // the address wraps on the memory size
  assign ofs  = addr[1:0];
  assign idx  = addr[DMEM_AW+1:2];
  assign word = mem[idx];

  always_comb begin
    case (size)
      MEM_BYTE: begin
        mis_raw   = 1'b0;
        be        = 4'b0001 << ofs;
        wdata_rep = {4{wdata[7:0]}};
      end
      MEM_HALF: begin
        mis_raw   = ofs[0];
        be        = 4'b0011 << ofs;
        wdata_rep = {2{wdata[15:0]}};
      end
      default: begin
        mis_raw   = ofs != 2'b00;
        be        = 4'b1111;
        wdata_rep = wdata;
      end
    endcase
  end

  assign misaligned = (ren || wen) && mis_raw;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wen && !misaligned) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          mem[idx][8*b +: 8] <= wdata_rep[8*b +: 8];
        end
      end
    end
  end

  // selected byte or half moved down to bit 0
  assign lane = word >> {ofs, 3'b000};

  always_comb begin
    case (size)
      MEM_BYTE: rdata = {{24{!unsigned_ld && lane[7]}}, lane[7:0]};
      MEM_HALF: rdata = {{16{!unsigned_ld && lane[15]}}, lane[15:0]};
      default:  rdata = word;
    endcase
  end

  assert property (@(posedge clock) disable iff (!rst_n)
    (wen && misaligned) |=> (mem[$past(idx)] == $past(word)))
    else $error("lsu: misaligned store changed memory");

endmodule

// File: design/regfile.sv
module regfile (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic [rv_isa_pkg::REG_AW-1:0] raddr1,
  input  logic [rv_isa_pkg::REG_AW-1:0] raddr2,
  output logic [rv_isa_pkg::XLEN-1:0]   rdata1,
  output logic [rv_isa_pkg::XLEN-1:0]   rdata2,
  input  logic                          wen,
  input  logic [rv_isa_pkg::REG_AW-1:0] waddr,
  input  logic [rv_isa_pkg::XLEN-1:0]   wdata
);

  import rv_isa_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // a write aimed at x0 must not change it
  assert property (@(posedge clock) disable iff (!rst_n)
    (wen && waddr == '0) |=> (regs[0] == '0))
    else $error("regfile: x0 no longer reads zero");

endmodule

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

  // data path and register file geometry
  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_AW = $clog2(NUM_REGS);

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b01_101_11,
    OPC_AUIPC  = 7'b00_101_11,
    OPC_JAL    = 7'b11_011_11,
    OPC_JALR   = 7'b11_001_11,
    OPC_BRANCH = 7'b11_000_11,
    OPC_LOAD   = 7'b00_000_11,
    OPC_STORE  = 7'b01_000_11,
    OPC_OP_IMM = 7'b00_100_11,
    OPC_OP     = 7'b01_100_11
  } opcode_e;

  // funct3 of OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store widths where bit 2 marks zero extension
  localparam logic [2:0] F3_MEM_B  = 3'b000;
  localparam logic [2:0] F3_MEM_H  = 3'b001;
  localparam logic [2:0] F3_MEM_W  = 3'b010;
  localparam logic [2:0] F3_MEM_BU = 3'b100;
  localparam logic [2:0] F3_MEM_HU = 3'b101;

  localparam logic [2:0] F3_JALR = 3'b000;

  // ALT selects SUB and the arithmetic right shift
  localparam logic [6:0] FUNCT7_BASE = 7'b00000_00;
  localparam logic [6:0] FUNCT7_ALT  = 7'b01000_00;

endpackage

// File: dv/core_tb.sv
module core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  localparam int N_ALU = 200;
  localparam int N_MEM = 120;
  localparam int N_FLOW = 150;
  localparam int N_MIX = 400;
  // one clock per test step plus reset and the fixed sequences
  localparam int MAX_CYCLES = 80 + N_ALU + 2 * N_MEM + 2 * N_FLOW + N_MIX;

  logic            clock;
  logic            rst_n;
  logic [31:0]     inst;
  logic            ivalid;
  logic [31:0]     pc;
  commit_t         commit;

  // reference state and the expected commit of the current cycle
  logic [31:0]     m_regs [NUM_REGS];
  logic [31:0]     m_mem [DMEM_WORDS];
  logic [31:0]     m_pc;
  logic            exp_valid;
  logic            exp_wen;
  logic [4:0]      exp_rd;
  logic [31:0]     exp_pc;
  logic [31:0]     exp_npc;
  logic [31:0]     exp_wdata;

  logic [15:0]     lfsr;
  logic [31:0]     inst_mix;
  int              errors;
  int              checks;
  int              test_err_base;
  int              tests_passed;
  int              tests_failed;

  core_top uut (
    .clock  (clock),
    .rst_n  (rst_n),
    .inst   (inst),
    .ivalid (ivalid),
    .pc     (pc),
    .commit (commit)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    #(MAX_CYCLES * 10 + 500);
    $display("watchdog expired before all tests finished");
    $display("Something failed");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd, opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  // imm is the byte offset whose bit 0 is dropped
  function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [31:0] imm, rd, opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] gen_lui();
    return enc_u(rand_bits(20), rand_bits(5), (rand_bits(1) == 1) ? 32'h37 : 32'h17);
  endfunction

  function automatic logic [31:0] gen_alu();
    logic [31:0] f3;
    logic [31:0] f7;
    logic [31:0] imm;
    f3 = rand_bits(3);
    f7 = 32'h0;
    if (rand_bits(1) == 1) begin
      if ((f3 == 0 || f3 == 5) && rand_bits(1) == 1) begin
        f7 = 32'h20;
      end
      return enc_r(f7, rand_bits(5), rand_bits(5), f3, rand_bits(5), 32'h33);
    end
    if (f3 == 1 || f3 == 5) begin
      if (f3 == 5 && rand_bits(1) == 1) begin
        f7 = 32'h20;
      end
      imm = (f7 << 5) | rand_bits(5);
    end else begin
      imm = rand_bits(12);
    end
    return enc_i(imm, rand_bits(5), f3, rand_bits(5), 32'h13);
  endfunction

  // bases live in x1..x3 with offsets from -32 to 31
  function automatic logic [31:0] gen_store();
    return enc_s(rand_bits(6) - 32, rand_bits(5), 1 + rand_bits(2) % 3, rand_bits(2) % 3);
  endfunction

  function automatic logic [31:0] gen_load();
    logic [31:0] f3;
    f3 = rand_bits(3);
    if (f3 == 3) begin
      f3 = 2;
    end else if (f3 > 5) begin
      f3 = f3 - 6;
    end
    return enc_i(rand_bits(6) - 32, 1 + rand_bits(2) % 3, f3, 4 + rand_bits(5) % 28, 32'h03);
  endfunction

  function automatic logic [31:0] gen_flow();
    logic [31:0] kind;
    logic [31:0] f3;
    logic [31:0] rs1;
    logic [31:0] rs2;
    kind = rand_bits(2);
    rs1 = rand_bits(5);
    rs2 = rand_bits(5);
    if (kind == 2) begin
      return enc_j(rand_bits(21), rand_bits(5));
    end
    if (kind == 3) begin
      return enc_i(rand_bits(12), rs1, 0, rand_bits(5), 32'h67);
    end
    f3 = rand_bits(3);
    if (f3 == 2 || f3 == 3) begin
      f3 = f3 + 2;
    end
    // equal operands make taken BEQ and BGE likely
    if (rand_bits(1) == 1) begin
      rs2 = rs1;
    end
    return enc_b(rand_bits(13), rs2, rs1, f3);
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'b0, $signed(x) < $signed(y)};
      3'd3: r = {31'b0, x < y};
      3'd4: r = x ^ y;
      3'd6: r = x | y;
      3'd7: r = x & y;
      default: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      3'd7: return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  task automatic model_reset();
    m_pc = RESET_PC;
    for (int k = 0; k < NUM_REGS; k++) begin
      m_regs[k] = '0;
    end
    for (int k = 0; k < DMEM_WORDS; k++) begin
      m_mem[k] = '0;
    end
  endtask

  // expected commit from the state before the edge followed by the state update
  task automatic model_exec(input logic [31:0] i, input logic v);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] ld;
    logic [31:0] res;
    logic [31:0] npc;
    logic [DMEM_AW-1:0] idx;
    logic        wen;
    opc = i[6:0];
    f3 = i[14:12];
    f7 = i[31:25];
    a = m_regs[i[19:15]];
    b = m_regs[i[24:20]];
    imm_i = {{20{i[31]}}, i[31:20]};
    res = '0;
    wen = 1'b0;
    npc = m_pc + 32'd4;
    addr = a + imm_i;
    if (opc == 7'h23) begin
      addr = a + {{20{i[31]}}, i[31:25], i[11:7]};
    end
    idx = addr[DMEM_AW+1:2];
    ld = m_mem[idx] >> {addr[1:0], 3'b000};
    case (opc)
      7'h37: begin
        wen = 1'b1;
        res = {i[31:12], 12'h000};
      end
      7'h17: begin
        wen = 1'b1;
        res = m_pc + {i[31:12], 12'h000};
      end
      7'h6f: begin
        wen = 1'b1;
        res = m_pc + 32'd4;
        npc = m_pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      end
      7'h67: begin
        if (f3 == 3'd0) begin
          wen = 1'b1;
          res = m_pc + 32'd4;
          npc = (a + imm_i) & ~32'h1;
        end
      end
      7'h63: begin
        if (branch_taken(f3, a, b)) begin
          npc = m_pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        end
      end
      7'h03: begin
        case (f3)
          3'd0: res = {{24{ld[7]}}, ld[7:0]};
          3'd4: res = {24'h0, ld[7:0]};
          3'd1: res = {{16{ld[15]}}, ld[15:0]};
          3'd5: res = {16'h0, ld[15:0]};
          default: res = m_mem[idx];
        endcase
        wen = (f3 == 3'd0 || f3 == 3'd4) ||
              ((f3 == 3'd1 || f3 == 3'd5) && !addr[0]) ||
              (f3 == 3'd2 && addr[1:0] == 2'b00);
      end
      7'h23: begin
        if (v && f3 == 3'd0) begin
          m_mem[idx][{addr[1:0], 3'b000} +: 8] = b[7:0];
        end else if (v && f3 == 3'd1 && !addr[0]) begin
          m_mem[idx][{addr[1], 4'b0000} +: 16] = b[15:0];
        end else if (v && f3 == 3'd2 && addr[1:0] == 2'b00) begin
          m_mem[idx] = b;
        end
      end
      7'h13: begin
        wen = (f3 == 3'd1) ? (f7 == 7'h00) :
              ((f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1);
        res = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
      end
      7'h33: begin
        wen = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        res = alu_ref(f3, f7[5], a, b);
      end
      default: wen = 1'b0;
    endcase
    exp_valid = v;
    exp_wen = v && wen;
    exp_rd = i[11:7];
    exp_pc = m_pc;
    exp_npc = npc;
    exp_wdata = res;
    if (v) begin
      if (wen && i[11:7] != 5'd0) begin
        m_regs[i[11:7]] = res;
      end
      m_pc = npc;
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_commit();
    compare("pc", pc, exp_pc);
    compare("commit.valid", 32'(commit.valid), 32'(exp_valid));
    compare("commit.reg_wen", 32'(commit.reg_wen), 32'(exp_wen));
    if (exp_valid) begin
      compare("commit.pc", commit.pc, exp_pc);
      compare("commit.next_pc", commit.next_pc, exp_npc);
    end
    if (exp_wen) begin
      compare("commit.rd", 32'(commit.rd), 32'(exp_rd));
      compare("commit.wdata", commit.wdata, exp_wdata);
    end
  endtask

  // drive on the rising edge and check in the middle of the cycle
  task automatic run_inst(input logic [31:0] i, input logic v);
    @(posedge clock);
    inst <= i;
    ivalid <= v;
    @(negedge clock);
    model_exec(i, v);
    check_commit();
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - test_err_base;
    if (n == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, n);
    end
    test_err_base = errors;
  endtask

  initial begin
    rst_n = 1'b0;
    inst = '0;
    ivalid = 1'b0;
    lfsr = 16'd84;
    errors = 0;
    checks = 0;
    test_err_base = 0;
    tests_passed = 0;
    tests_failed = 0;
    model_reset();
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;

    @(negedge clock);
    compare("pc", pc, RESET_PC);
    compare("commit.valid", 32'(commit.valid), 32'h0);
    for (int k = 0; k < 8; k++) begin
      run_inst(gen_lui(), 1'b1);
      run_inst(enc_i(rand_bits(12), rand_bits(5), 0, rand_bits(5), 32'h13), 1'b1);
    end
    run_inst(enc_u(rand_bits(20), 0, 32'h37), 1'b1);
    run_inst(enc_i(32'h7ff, 0, 0, 0, 32'h13), 1'b1);
    // x0 must still read zero as an operand
    run_inst(enc_r(0, 0, 0, 0, 5, 32'h33), 1'b1);
    end_test("reset_lui_opimm");

    for (int k = 0; k < 16; k++) begin
      run_inst(gen_lui(), 1'b1);
    end
    for (int k = 0; k < N_ALU; k++) begin
      run_inst(gen_alu(), 1'b1);
    end
    end_test("alu_random");

    for (int k = 1; k <= 3; k++) begin
      run_inst(enc_i(rand_bits(8) << 2, 0, 0, k, 32'h13), 1'b1);
    end
    // misaligned word and half loads off a word-aligned base
    run_inst(enc_i(1, 1, 2, 9, 32'h03), 1'b1);
    run_inst(enc_i(3, 2, 5, 10, 32'h03), 1'b1);
    for (int k = 0; k < N_MEM; k++) begin
      run_inst(gen_store(), 1'b1);
      run_inst(gen_load(), 1'b1);
    end
    end_test("load_store");

    for (int k = 0; k < N_FLOW; k++) begin
      run_inst(gen_flow(), 1'b1);
      if (rand_bits(2) == 0) begin
        run_inst(rand_bits(32), 1'b0);
      end
    end
    end_test("branch_jump");

    for (int k = 0; k < N_MIX; k++) begin
      case (rand_bits(3))
        32'd3: inst_mix = gen_store();
        32'd4: inst_mix = gen_load();
        32'd5: inst_mix = gen_flow();
        32'd6: inst_mix = gen_lui();
        32'd7: inst_mix = rand_bits(32);
        default: inst_mix = gen_alu();
      endcase
      run_inst(inst_mix, rand_bits(2) != 0);
    end
    run_inst(32'h0, 1'b0);
    end_test("mixed_stream");

    $display("summary: %0d tests passed, %0d failed, %0d checks, %0d mismatches",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module core_tb \
  --Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: vlog.f
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/idu.sv
design/alu.sv
design/regfile.sv
design/lsu.sv
design/core_top.sv
dv/core_tb.sv
